/* hdl/uart_tx_settings.svh */
// Sizing constants for the UART transmit path
// Include wherever FIFO depth, pointer or divisor widths are needed
`ifndef UART_TX_SETTINGS_SVH
`define UART_TX_SETTINGS_SVH

// ------------------------------
// Transmit FIFO
// ------------------------------

// Entries held by the transmit FIFO
`define UART_TX_FIFO_DEPTH 512

// RAM address width, wraps at the FIFO depth
`define UART_TX_PTR_W 9

// ------------------------------
// Baud generator
// ------------------------------

// Width of the programmable 16x divisor
`define UART_TX_DIV_W 16

`endif

/* hdl/uart_tx_pkg.sv */
// Shared types for the UART transmit path
// Modules pull these in with a wildcard import in their header
`include "uart_tx_settings.svh"

package uart_tx_pkg;

    // One data byte from the bus
    typedef logic [7:0] uart_byte_t;

    // Fill count, one bit wider than the address so 512 fits
    typedef logic [`UART_TX_PTR_W:0] fifo_level_t;

    // RAM address
    typedef logic [`UART_TX_PTR_W-1:0] fifo_ptr_t;

    // Baud divisor, bit time is 16 x divisor clocks
    typedef logic [`UART_TX_DIV_W-1:0] baud_div_t;

    // Line control, a subset of the 16550 LCR
    typedef struct packed {
        logic [1:0] word_len;     // 0..3 select 5..8 data bits
        logic       two_stop;     // Two stop bits when set
        logic       parity_en;    // Append a parity bit
        logic       even_parity;  // Even when set, odd otherwise
        logic       set_break;    // Hold the line low
    } line_ctrl_t;

    // Transmitter frame states
    typedef enum logic [2:0] {
        IDLE,
        START,
        DATA,
        PARITY,
        STOP
    } tx_state_t;

endpackage

/* hdl/uart_fifo_ram.sv */
// Portable 512x8 storage for the transmit FIFO
// Show-ahead read, the word at the read pointer is always on rd_dat_o
// Strobes arrive already qualified, no full or empty checks in here
`include "uart_tx_settings.svh"

module uart_fifo_ram
    import uart_tx_pkg::*;
(
    input  logic       WBs_CLK_i,
    input  logic       WBs_RST_i,

    // Pointer reset
    input  logic       flush_i,

    // Write side
    input  logic       wr_en_i,
    input  uart_byte_t wr_dat_i,

    // Read side
    input  logic       rd_en_i,
    output uart_byte_t rd_dat_o
);

    // ------------------------------
    // Storage and pointers
    // ------------------------------

    uart_byte_t mem [`UART_TX_FIFO_DEPTH];

    // Next slot to write
    fifo_ptr_t  wr_ptr;

    // Oldest stored byte
    fifo_ptr_t  rd_ptr;

    // Write pointer
    // Wraps at the depth by width alone
    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
            wr_ptr <= '0;
        else if (flush_i)
            wr_ptr <= '0;
        else if (wr_en_i)
            wr_ptr <= wr_ptr + 1'b1;
    end

    // Read pointer
    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
            rd_ptr <= '0;
        else if (flush_i)
            rd_ptr <= '0;
        else if (rd_en_i)
            rd_ptr <= rd_ptr + 1'b1;
    end

    // ------------------------------
    // Array access
    // ------------------------------

    // Byte write
    always_ff @(posedge WBs_CLK_i)
    begin
        if (wr_en_i)
            mem[wr_ptr] <= wr_dat_i;
    end

    // Head of queue, visible before the pop
    assign rd_dat_o = mem[rd_ptr];

endmodule

/* hdl/uart_tx_fifo.sv */
// Transmit FIFO wrapper around the byte RAM
// Qualifies push and pop, tracks level and empty, flush clears both
// Output data reads as zero while the FIFO is empty
`include "uart_tx_settings.svh"

module uart_tx_fifo
    import uart_tx_pkg::*;
(
    input  logic        WBs_CLK_i,
    input  logic        WBs_RST_i,

    // Bus write data
    input  uart_byte_t  wbs_dat_i,

    // Control strobes
    input  logic        tx_fifo_flush_i,
    input  logic        tx_fifo_push_i,
    input  logic        tx_fifo_pop_i,

    // Toward the transmitter
    output uart_byte_t  tx_fifo_dat_o,
    output logic        tx_fifo_empty_o,
    output fifo_level_t tx_fifo_level_o
);

    // ------------------------------
    // Strobe qualification
    // ------------------------------

    logic        push_ok;
    logic        pop_ok;
    uart_byte_t  ram_dat;
    fifo_level_t level_nxt;
    logic        empty_nxt;

    // Drop pushes when full, flush wins over everything
    assign push_ok = tx_fifo_push_i & ~tx_fifo_flush_i &
                     (tx_fifo_level_o < fifo_level_t'(`UART_TX_FIFO_DEPTH));

    // No pop from an empty FIFO
    assign pop_ok  = tx_fifo_pop_i & ~tx_fifo_flush_i & ~tx_fifo_empty_o;

    // ------------------------------
    // Level and empty flag
    // ------------------------------

    always_comb
    begin
        level_nxt = tx_fifo_level_o;
        empty_nxt = tx_fifo_empty_o;
        if (tx_fifo_flush_i)
        begin
            level_nxt = '0;
            empty_nxt = 1'b1;
        end
        else
        begin
            case ({pop_ok, push_ok})
                // Push alone
                2'b01:
                begin
                    level_nxt = tx_fifo_level_o + 1'b1;
                    empty_nxt = 1'b0;
                end
                // Pop alone, last byte leaves
                2'b10:
                begin
                    level_nxt = tx_fifo_level_o - 1'b1;
                    empty_nxt = (tx_fifo_level_o == fifo_level_t'(1));
                end
                // Idle or push with pop, hold
                default:
                begin
                    level_nxt = tx_fifo_level_o;
                    empty_nxt = tx_fifo_empty_o;
                end
            endcase
        end
    end

    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            tx_fifo_level_o <= '0;
            tx_fifo_empty_o <= 1'b1;
        end
        else
        begin
            tx_fifo_level_o <= level_nxt;
            tx_fifo_empty_o <= empty_nxt;
        end
    end

    // Stale RAM contents never reach the transmitter
    assign tx_fifo_dat_o = tx_fifo_empty_o ? '0 : ram_dat;

    // ------------------------------
    // Storage
    // ------------------------------

    uart_fifo_ram u_fifo_ram (
        .WBs_CLK_i (WBs_CLK_i),
        .WBs_RST_i (WBs_RST_i),
        .flush_i   (tx_fifo_flush_i),
        .wr_en_i   (push_ok),
        .wr_dat_i  (wbs_dat_i),
        .rd_en_i   (pop_ok),
        .rd_dat_o  (ram_dat)
    );

endmodule

/* hdl/uart_transmitter.sv */
// Serial frame generator for the UART transmit path
// Pops one byte from the FIFO when idle and sends start, data, parity, stop
// Bit time is 16 ticks, each tick is divisor clocks long

module uart_transmitter
    import uart_tx_pkg::*;
(
    input  logic       WBs_CLK_i,
    input  logic       WBs_RST_i,

    // Line settings, sampled at each pop
    input  baud_div_t  divisor_i,
    input  line_ctrl_t line_ctrl_i,

    // FIFO read side
    input  logic       tx_fifo_empty_i,
    input  uart_byte_t tx_fifo_dat_i,
    output logic       tx_fifo_pop_o,

    // Serial line and status
    output logic       sout_o,
    output logic       tx_idle_o
);

    tx_state_t  state;

    // Baud timing
    baud_div_t  div_cnt;
    logic [3:0] tick_cnt;
    logic       tick;
    logic       bit_end;

    // Frame bookkeeping
    logic [2:0] bit_cnt;
    logic [2:0] last_bit;
    logic       stop_cnt;

    // Per-frame copies
    uart_byte_t shift_q;
    line_ctrl_t lc_q;
    baud_div_t  div_q;
    logic       par_q;

    logic       line_bit;

    // ------------------------------
    // Baud tick and bit end
    // ------------------------------

    assign tick     = (div_cnt == div_q - 1'b1);
    assign bit_end  = tick & (tick_cnt == 4'hf);

    // Index of the final data bit, word_len + 4
    assign last_bit = {1'b1, lc_q.word_len};

    // Fetch next byte whenever idle and data waits
    assign tx_fifo_pop_o = (state == IDLE) & ~tx_fifo_empty_i;
    assign tx_idle_o     = (state == IDLE);

    // ------------------------------
    // Frame FSM
    // ------------------------------

    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            state    <= IDLE;
            div_cnt  <= '0;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            stop_cnt <= 1'b0;
        end
        else
        begin
            // Counters run only inside a frame
            if (state == IDLE)
            begin
                div_cnt  <= '0;
                tick_cnt <= '0;
            end
            else if (tick)
            begin
                div_cnt  <= '0;
                tick_cnt <= tick_cnt + 4'd1;
            end
            else
                div_cnt <= div_cnt + 1'b1;

            case (state)
                IDLE:
                    if (tx_fifo_pop_o)
                        state <= START;
                START:
                    if (bit_end)
                    begin
                        state    <= DATA;
                        bit_cnt  <= '0;
                        stop_cnt <= 1'b0;
                    end
                DATA:
                    if (bit_end)
                    begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == last_bit)
                            state <= lc_q.parity_en ? PARITY : STOP;
                    end
                PARITY:
                    if (bit_end)
                        state <= STOP;
                STOP:
                    if (bit_end)
                    begin
                        // Second stop bit when asked for
                        if (lc_q.two_stop && !stop_cnt)
                            stop_cnt <= 1'b1;
                        else
                            state <= IDLE;
                    end
                default:
                    state <= IDLE;
            endcase
        end
    end

    // ------------------------------
    // Shift register and parity
    // ------------------------------

    always_ff @(posedge WBs_CLK_i)
    begin
        if (tx_fifo_pop_o)
        begin
            shift_q <= tx_fifo_dat_i;
            lc_q    <= line_ctrl_i;
            div_q   <= divisor_i;
            par_q   <= 1'b0;
        end
        else if ((state == DATA) && bit_end)
        begin
            // LSB first, parity over sent bits only
            shift_q <= {1'b0, shift_q[7:1]};
            par_q   <= par_q ^ shift_q[0];
        end
    end

    // Line level per state
    always_comb
    begin
        case (state)
            START:   line_bit = 1'b0;
            DATA:    line_bit = shift_q[0];
            PARITY:  line_bit = lc_q.even_parity ? par_q : ~par_q;
            default: line_bit = 1'b1;
        endcase
    end

    // Break holds the line low, frame timing keeps running
    assign sout_o = line_bit & ~line_ctrl_i.set_break;

endmodule

/* hdl/uart_tx_top.sv */
// Transmit half of the UART
// Bus pushes bytes into the FIFO, the transmitter drains it onto sout_o
// Divisor and line control come from an external register bank

module uart_tx_top
    import uart_tx_pkg::*;
(
    input  logic        WBs_CLK_i,
    input  logic        WBs_RST_i,

    // Bus side
    input  uart_byte_t  wbs_dat_i,
    input  logic        tx_fifo_push_i,
    input  logic        tx_fifo_flush_i,

    // Line configuration
    input  baud_div_t   divisor_i,
    input  line_ctrl_t  line_ctrl_i,

    // Serial out and status
    output logic        sout_o,
    output fifo_level_t tx_fifo_level_o,
    output logic        tx_fifo_empty_o,
    output logic        tx_idle_o
);

    // FIFO to transmitter
    uart_byte_t tx_fifo_dat;
    logic       tx_fifo_pop;

    uart_tx_fifo u_tx_fifo (
        .WBs_CLK_i       (WBs_CLK_i),
        .WBs_RST_i       (WBs_RST_i),
        .wbs_dat_i       (wbs_dat_i),
        .tx_fifo_flush_i (tx_fifo_flush_i),
        .tx_fifo_push_i  (tx_fifo_push_i),
        .tx_fifo_pop_i   (tx_fifo_pop),
        .tx_fifo_dat_o   (tx_fifo_dat),
        .tx_fifo_empty_o (tx_fifo_empty_o),
        .tx_fifo_level_o (tx_fifo_level_o)
    );

    // Empty flag also gates the pop
    uart_transmitter u_transmitter (
        .WBs_CLK_i       (WBs_CLK_i),
        .WBs_RST_i       (WBs_RST_i),
        .divisor_i       (divisor_i),
        .line_ctrl_i     (line_ctrl_i),
        .tx_fifo_empty_i (tx_fifo_empty_o),
        .tx_fifo_dat_i   (tx_fifo_dat),
        .tx_fifo_pop_o   (tx_fifo_pop),
        .sout_o          (sout_o),
        .tx_idle_o       (tx_idle_o)
    );

endmodule

/* testbench/uart_tx_checker.sv */
// Scoreboard for the UART transmit path
// Models the FIFO level and byte order, decodes sout_o at mid-bit
// and compares every frame, level and status flag against the model
`include "uart_tx_settings.svh"

module uart_tx_checker
    import uart_tx_pkg::*;
(
    input  logic        WBs_CLK_i,
    input  logic        WBs_RST_i,
    input  uart_byte_t  wbs_dat_i,
    input  logic        tx_fifo_push_i,
    input  logic        tx_fifo_flush_i,
    input  baud_div_t   divisor_i,
    input  line_ctrl_t  line_ctrl_i,
    input  logic        sout_i,
    input  fifo_level_t tx_fifo_level_i,
    input  logic        tx_fifo_empty_i,
    input  logic        tx_idle_i,
    output int          error_cnt_o,
    output int          frame_cnt_o,
    output int          pending_o
);
    timeunit 1ns;
    timeprecision 10ps;

    // Model FIFO contents and frames handed to the transmitter
    uart_byte_t byte_q[$];
    uart_byte_t frame_q[$];
    int         model_level;
    logic       pop_now;
    logic       pop_prev;
    logic       idle_prev;
    logic       rst_seen;

    // Decoder state
    logic       sout_prev;
    logic       busy;

    initial
    begin
        error_cnt_o = 0;
        frame_cnt_o = 0;
        sout_prev   = 1'b1;
        busy        = 1'b0;
    end

    assign pending_o = frame_q.size() + int'(busy);

    task automatic value_error(input string name, input int exp, input int act);
        $display("Fail at %0t ns: %s expected %0h got %0h", $time, name, exp, act);
        error_cnt_o++;
    endtask

    task automatic event_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        error_cnt_o++;
    endtask

    // ------------------------------
    // FIFO model and status checks
    // ------------------------------

    always @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            byte_q.delete();
            frame_q.delete();
            model_level = 0;
            pop_prev    = 1'b0;
            idle_prev   = 1'b1;
            rst_seen    = 1'b1;
        end
        else
        begin
            // Idle line right after reset
            if (rst_seen)
            begin
                if (!sout_i)
                    value_error("sout_o after reset", 1, 0);
                if (!tx_idle_i)
                    value_error("tx_idle_o after reset", 1, 0);
                rst_seen = 1'b0;
            end
            if (int'(tx_fifo_level_i) != model_level)
                value_error("tx_fifo_level_o", model_level, int'(tx_fifo_level_i));
            if (tx_fifo_empty_i != (model_level == 0))
                value_error("tx_fifo_empty_o", int'(model_level == 0), int'(tx_fifo_empty_i));
            if (idle_prev && !tx_idle_i && !pop_prev)
                event_error("transmitter started a frame with no byte queued");
            if (pop_prev && tx_idle_i)
                event_error("transmitter stayed idle with a byte queued");
            if (line_ctrl_i.set_break && sout_i)
                value_error("sout_o during break", 0, 1);

            // Pop happens while idle with data, flush blocks it
            pop_now = tx_idle_i && (model_level > 0) && !tx_fifo_flush_i;
            if (tx_fifo_flush_i)
            begin
                byte_q.delete();
                model_level = 0;
            end
            else
            begin
                if (tx_fifo_push_i && (model_level < `UART_TX_FIFO_DEPTH))
                begin
                    byte_q.push_back(wbs_dat_i);
                    model_level++;
                end
                if (pop_now)
                begin
                    frame_q.push_back(byte_q.pop_front());
                    model_level--;
                end
            end
            pop_prev  = pop_now;
            idle_prev = tx_idle_i;
        end
    end

    // ------------------------------
    // Serial frame decoder
    // ------------------------------

    task automatic decode_frame();
        line_ctrl_t lc;
        int         bit_len;
        int         nbits;
        uart_byte_t data;
        uart_byte_t exp;
        logic       par_bit;
        logic       par_exp;
        lc      = line_ctrl_i;
        bit_len = 16 * int'(divisor_i);
        nbits   = int'(lc.word_len) + 5;
        data    = '0;
        par_bit = 1'b0;
        busy    = 1'b1;
        // Start edge seen one cycle late, land on mid-bit
        repeat (bit_len / 2 - 1) @(posedge WBs_CLK_i);
        if (sout_i)
            value_error("sout_o start bit", 0, 1);
        for (int i = 0; i < nbits; i++)
        begin
            repeat (bit_len) @(posedge WBs_CLK_i);
            data[i] = sout_i;
        end
        if (lc.parity_en)
        begin
            repeat (bit_len) @(posedge WBs_CLK_i);
            par_bit = sout_i;
        end
        for (int s = 0; s < (lc.two_stop ? 2 : 1); s++)
        begin
            repeat (bit_len) @(posedge WBs_CLK_i);
            if (!sout_i)
                value_error("sout_o stop bit", 1, 0);
        end
        busy = 1'b0;
        if (frame_q.size() == 0)
            event_error("frame seen on sout_o with no byte expected");
        else
        begin
            exp = frame_q.pop_front();
            exp = exp & uart_byte_t'((1 << nbits) - 1);
            if (data != exp)
                value_error("sout_o data", int'(exp), int'(data));
            // Even parity is the XOR of the data bits
            par_exp = lc.even_parity ? ^exp : ~^exp;
            if (lc.parity_en && (par_bit != par_exp))
                value_error("sout_o parity", int'(par_exp), int'(par_bit));
            frame_cnt_o++;
        end
    endtask

    always @(posedge WBs_CLK_i)
    begin
        if (!WBs_RST_i && sout_prev && !sout_i && !line_ctrl_i.set_break)
            decode_frame();
        sout_prev = sout_i;
    end

endmodule

/* testbench/tb_uart_tx.sv */
// Top testbench for the UART transmit path
// Random divisors, line settings and bytes from an LFSR, plus FIFO fill,
// flush and break phases, results come from the checker

module tb_uart_tx
    import uart_tx_pkg::*;
;
    timeunit 1ns;
    timeprecision 10ps;

    localparam int PHASES     = 10;
    localparam int PHASE_LEN  = 8;
    localparam int FILL_LEN   = 520;
    // Random phases, the flush phase and the fill
    localparam int TOTAL_LEN  = (PHASES + 1) * PHASE_LEN + FILL_LEN;
    // Bytes x 12 bits x 16 ticks x divisor 4 x 4 ns, plus margin
    localparam longint TIMEOUT_NS = longint'(TOTAL_LEN) * 12 * 16 * 4 * 4 + 50000;

    logic        clk;
    logic        rst;
    uart_byte_t  wbs_dat;
    logic        push;
    logic        flush;
    baud_div_t   divisor;
    line_ctrl_t  line_ctrl;
    logic        sout;
    fifo_level_t level;
    logic        empty;
    logic        idle;
    int          error_cnt;
    int          frame_cnt;
    int          pending;
    logic [31:0] lfsr_state;

    always #2 clk = ~clk;

    uart_tx_top u_dut (
        .WBs_CLK_i       (clk),
        .WBs_RST_i       (rst),
        .wbs_dat_i       (wbs_dat),
        .tx_fifo_push_i  (push),
        .tx_fifo_flush_i (flush),
        .divisor_i       (divisor),
        .line_ctrl_i     (line_ctrl),
        .sout_o          (sout),
        .tx_fifo_level_o (level),
        .tx_fifo_empty_o (empty),
        .tx_idle_o       (idle)
    );

    uart_tx_checker u_checker (
        .WBs_CLK_i       (clk),
        .WBs_RST_i       (rst),
        .wbs_dat_i       (wbs_dat),
        .tx_fifo_push_i  (push),
        .tx_fifo_flush_i (flush),
        .divisor_i       (divisor),
        .line_ctrl_i     (line_ctrl),
        .sout_i          (sout),
        .tx_fifo_level_i (level),
        .tx_fifo_empty_i (empty),
        .tx_idle_i       (idle),
        .error_cnt_o     (error_cnt),
        .frame_cnt_o     (frame_cnt),
        .pending_o       (pending)
    );

    // Galois LFSR, one step per bit taken
    function logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'hb4bcd35c) : (lfsr_state >> 1);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // Idle line, empty FIFO and no frame left to decode
    task wait_drain();
        do
            @(negedge clk);
        while (!(idle && empty && (pending == 0)));
    endtask

    // New settings while idle
    task pick_settings(input logic fixed_div);
        divisor   = fixed_div ? baud_div_t'(4) : baud_div_t'(32'd1 + rand_bits(2));
        line_ctrl = line_ctrl_t'(rand_bits(6));
        line_ctrl.set_break = 1'b0;
    endtask

    task push_bytes(input int count, input logic with_gaps);
        for (int i = 0; i < count; i++)
        begin
            wbs_dat = uart_byte_t'(rand_bits(8));
            push    = 1'b1;
            @(negedge clk);
            push = 1'b0;
            if (with_gaps)
                repeat (int'(rand_bits(2))) @(negedge clk);
        end
    endtask

    task run_phase();
        wait_drain();
        pick_settings(1'b0);
        push_bytes(PHASE_LEN, 1'b1);
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------

    initial
    begin
        clk        = 1'b0;
        rst        = 1'b1;
        wbs_dat    = '0;
        push       = 1'b0;
        flush      = 1'b0;
        divisor    = baud_div_t'(1);
        line_ctrl  = '0;
        lfsr_state = 32'hbac6;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int p = 0; p < PHASES - 2; p++)
            run_phase();

        // Fill past full, then send every accepted byte
        wait_drain();
        pick_settings(1'b1);
        push_bytes(FILL_LEN, 1'b0);
        wait_drain();

        // Flush mid-frame with bytes still queued
        pick_settings(1'b0);
        push_bytes(PHASE_LEN, 1'b0);
        while (idle)
            @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        wait_drain();
        repeat (200) @(negedge clk);

        // Break with the line otherwise idle
        line_ctrl.set_break = 1'b1;
        repeat (40) @(negedge clk);
        line_ctrl.set_break = 1'b0;

        // Frames resume after break
        for (int p = 0; p < 2; p++)
            run_phase();
        wait_drain();
        repeat (10) @(negedge clk);

        $display("Frames checked %0d, errors %0d", frame_cnt, error_cnt);
        if (error_cnt == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

    // Watchdog
    initial
    begin
        #(TIMEOUT_NS);
        $display("Error: run did not finish within %0d ns", TIMEOUT_NS);
        $display("Frames checked %0d, errors %0d", frame_cnt, error_cnt);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

/* uart_tx.f */
+incdir+hdl
hdl/uart_tx_pkg.sv
hdl/uart_fifo_ram.sv
hdl/uart_tx_fifo.sv
hdl/uart_transmitter.sv
hdl/uart_tx_top.sv
testbench/uart_tx_checker.sv
testbench/tb_uart_tx.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the UART transmit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f uart_tx.f --top-module tb_uart_tx -o sim_uart_tx

./obj_dir/sim_uart_tx > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION PASSED" sim.log; then
    exit 0
else
    exit 1
fi
